//--- all.f
+incdir+testbench
hw/mbfPkg.sv
hw/permutePkg.sv
hw/permuteReqIf.sv
hw/botInputFifo.sv
hw/varSwapStage.sv
hw/permute67.sv
hw/permutGenerator.sv
hw/permuteTop.sv
testbench/permuteTb.sv

//--- hw/botInputFifo.sv
`timescale 1ns/1ps

module botInputFifo
    import mbfPkg::*, permutePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  mbfWord inBot,
    input  logic   inValid,
    output logic   inReady,
    output mbfWord fifoBot,
    output logic   fifoValid,
    input  logic   fifoReady
);

    localparam int fifoDepth = 1 << fifoDepthLog2;

    mbfWord mem [fifoDepth];

    logic [fifoDepthLog2-1:0] wrPtr;
    logic [fifoDepthLog2-1:0] rdPtr;
    logic [fifoDepthLog2:0]   count;  // one extra bit to tell full from empty
    logic                     doWrite;
    logic                     doRead;

    assign inReady   = (count != (fifoDepthLog2+1)'(fifoDepth));
    assign fifoValid = (count != '0);
    assign fifoBot   = mem[rdPtr];

    assign doWrite = inValid && inReady;
    assign doRead  = fifoValid && fifoReady;

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= inBot;
        end
    end

endmodule

//--- hw/mbfPkg.sv
// truth table layout for 7-variable monotone Boolean functions
package mbfPkg;

    // number of input variables of one function
    localparam int numVars = 7;

    // one truth-table bit per input combination, bit x holds f(x)
    localparam int mbfBits = 1 << numVars;

    // address bit i of a truth-table index is variable i
    typedef logic [mbfBits-1:0] mbfWord;

endpackage

//--- hw/permutGenerator.sv
`timescale 1ns/1ps

module permutGenerator
    import mbfPkg::*, permutePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mbfWord   fifoBot,
    input  logic     fifoValid,
    output logic     fifoReady,
    permuteReqIf.gen req
);

    genState state;
    mbfWord  curBot;   // function of the running series
    varIndex p7;
    varIndex p6;
    logic    seriesEnd;
    logic    permuting;
    logic    take;

    assign permuting = (state == genPermuting);
    assign seriesEnd = (p7 == '0) && (p6 == '0);

    assign req.reqBot   = curBot;
    assign req.permut7  = p7;
    assign req.permut6  = p6;
    assign req.reqValid = permuting;
    assign req.reqLast  = permuting && seriesEnd;

    // a new function fits only when idle or when the last request leaves now
    assign fifoReady = !permuting || (seriesEnd && req.advance);
    assign take      = fifoReady && fifoValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= genIdle;
            p7    <= permut7Max;
            p6    <= permut6Max;
        end else if (take) begin
            // back-to-back series, no idle cycle in between
            state <= genPermuting;
            p7    <= permut7Max;
            p6    <= permut6Max;
        end else if (permuting && req.advance) begin
            if (seriesEnd) begin
                state <= genIdle;
            end else if (p7 == '0) begin
                p7 <= permut7Max;       // inner loop wraps
                p6 <= p6 - 3'd1;
            end else begin
                p7 <= p7 - 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            curBot <= fifoBot;
        end
    end

endmodule

//--- hw/permute67.sv
`timescale 1ns/1ps

module permute67
    import mbfPkg::*, permutePkg::*;
(
    input  logic       clk,
    input  logic       rst,
    permuteReqIf.dp    req,
    output mbfWord     outBot,
    output logic       outValid,
    output logic       outLast,
    input  logic       outReady
);

    mbfWord  stage1Bot;
    varIndex permut6D;   // p6 delayed to meet its own data
    varIndex stage2Idx;
    logic    valid1;
    logic    last1;

    // full stall, nothing moves unless the consumer takes data
    assign req.advance = outReady;

    assign stage2Idx = permut6D + 3'd1;

    varSwapStage #(.fixedVar(0)) swap0 (
        .clk     (clk),
        .swapIdx (req.permut7),
        .enable  (req.advance),
        .dataIn  (req.reqBot),
        .dataOut (stage1Bot)
    );

    varSwapStage #(.fixedVar(1)) swap1 (
        .clk     (clk),
        .swapIdx (stage2Idx),
        .enable  (req.advance),
        .dataIn  (stage1Bot),
        .dataOut (outBot)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid1   <= 1'b0;
            outValid <= 1'b0;
        end else if (req.advance) begin
            valid1   <= req.reqValid;
            outValid <= valid1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.advance) begin
            permut6D <= req.permut6;
            last1    <= req.reqLast;
            outLast  <= last1;
        end
    end

endmodule

//--- hw/permutePkg.sv
// permutation series description shared by generator and datapath
package permutePkg;

    // selects a variable 0..6, wide enough for 1+p6 as well
    typedef logic [2:0] varIndex;

    // p7 picks the partner of variable 0, counts 6 down to 0
    localparam varIndex permut7Max = 3'd6;

    // p6 picks partner 1+p6 of variable 1, counts 5 down to 0
    localparam varIndex permut6Max = 3'd5;

    // outputs per function
    localparam int permsPerBot = (int'(permut7Max) + 1) * (int'(permut6Max) + 1);

    // input FIFO holds 1 << fifoDepthLog2 functions
    localparam int fifoDepthLog2 = 2;

    typedef enum logic {
        genIdle,
        genPermuting
    } genState;

endpackage

//--- hw/permuteReqIf.sv
`timescale 1ns/1ps

// one permutation request per advancing cycle, generator to datapath
interface permuteReqIf
    import mbfPkg::*, permutePkg::*;
();

    mbfWord  reqBot;   // function being permuted
    varIndex permut7;
    varIndex permut6;
    logic    reqValid;
    logic    reqLast;  // final request of a series
    logic    advance;  // whole pipeline steps when high

    modport gen (
        output reqBot,
        output permut7,
        output permut6,
        output reqValid,
        output reqLast,
        input  advance
    );

    modport dp (
        input  reqBot,
        input  permut7,
        input  permut6,
        input  reqValid,
        input  reqLast,
        output advance
    );

endinterface

//--- hw/permuteTop.sv
`timescale 1ns/1ps

module permuteTop
    import mbfPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  mbfWord inBot,
    input  logic   inValid,
    output logic   inReady,
    output mbfWord outBot,
    output logic   outValid,
    input  logic   outReady,
    output logic   outLast
);

    mbfWord fifoBot;
    logic   fifoValid;
    logic   fifoReady;

    permuteReqIf req ();

    botInputFifo inFifo (
        .clk       (clk),
        .rst       (rst),
        .inBot     (inBot),
        .inValid   (inValid),
        .inReady   (inReady),
        .fifoBot   (fifoBot),
        .fifoValid (fifoValid),
        .fifoReady (fifoReady)
    );

    permutGenerator gen (
        .clk       (clk),
        .rst       (rst),
        .fifoBot   (fifoBot),
        .fifoValid (fifoValid),
        .fifoReady (fifoReady),
        .req       (req.gen)
    );

    // two swap stages, variable 0 first then variable 1
    permute67 dp (
        .clk      (clk),
        .rst      (rst),
        .req      (req.dp),
        .outBot   (outBot),
        .outValid (outValid),
        .outLast  (outLast),
        .outReady (outReady)
    );

endmodule

//--- hw/varSwapStage.sv
`timescale 1ns/1ps

module varSwapStage
    import mbfPkg::*, permutePkg::*;
#(
    parameter int fixedVar = 0
) (
    input  logic    clk,
    input  varIndex swapIdx,
    input  logic    enable,
    input  mbfWord  dataIn,
    output mbfWord  dataOut
);

    // truth-table index x with address bits a and b exchanged
    function automatic int swapAddr(input int x, input int a, input int b);
        int bitA;
        int bitB;
        int r;
        bitA = (x >> a) & 1;
        bitB = (x >> b) & 1;
        r = x & ~((1 << a) | (1 << b));
        r = r | (bitA << b) | (bitB << a);
        return r;
    endfunction

    mbfWord swapped [numVars];

    for (genvar p = 0; p < numVars; p++) begin : gPartner
        if (p == fixedVar) begin : gSelf
            assign swapped[p] = dataIn;  // swap with itself
        end else begin : gSwap
            for (genvar x = 0; x < mbfBits; x++) begin : gBit
                localparam int srcBit = swapAddr(x, fixedVar, p);
                assign swapped[p][x] = dataIn[srcBit];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            // indices past the last variable never occur, pass data then
            dataOut <= (int'(swapIdx) < numVars) ? swapped[swapIdx] : dataIn;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module permuteTb -f all.f -o permuteSim \
    || { echo "verilator build failed"; exit 1; }

simOut="$(./obj_dir/permuteSim)"
echo "$simOut"

echo "$simOut" | grep -q "^TEST PASSED$" && exit 0 || exit 1

//--- testbench/permuteModel.svh
`ifndef permuteModelSvh
`define permuteModelSvh

// expected stream, one entry per permutation still to come out of the DUT
mbfWord expBot[$];
bit     expLast[$];

// result bit x comes from source bit x with address bits a and b exchanged
function automatic mbfWord swapVars(input mbfWord src, input int a, input int b);
    mbfWord             res;
    logic [numVars-1:0] addr;
    logic               t;
    for (int x = 0; x < mbfBits; x++) begin
        addr    = numVars'(x);
        t       = addr[a];
        addr[a] = addr[b];
        addr[b] = t;
        res[x]  = src[addr];  // a == b leaves addr as it was
    end
    return res;
endfunction

// variable 0 with p7 first, then variable 1 with 1+p6
function automatic mbfWord applyPerm(input mbfWord src, input int p7, input int p6);
    mbfWord step;
    step = swapVars(src, 0, p7);
    return swapVars(step, 1, 1 + p6);
endfunction

// all 42 results of one accepted function, p6 outer and p7 inner, both counting down
function automatic void queueSeries(input mbfWord src);
    for (int p6 = int'(permut6Max); p6 >= 0; p6--) begin
        for (int p7 = int'(permut7Max); p7 >= 0; p7--) begin
            expBot.push_back(applyPerm(src, p7, p6));
            expLast.push_back((p6 == 0) && (p7 == 0));
        end
    end
endfunction

`endif

//--- testbench/permuteTb.sv
`timescale 1ns/1ps

module permuteTb
    import mbfPkg::*, permutePkg::*;
();

    localparam int numBots       = 30;
    localparam int timeoutCycles = numBots * permsPerBot * 3 + 200;

    logic   clk;
    logic   rst;
    mbfWord inBot;
    logic   inValid;
    logic   inReady;
    mbfWord outBot;
    logic   outValid;
    logic   outReady;
    logic   outLast;

    int seed = 32974;
    int botErrors = 0;
    int lastErrors = 0;
    int flowErrors = 0;
    int outCount = 0;    // outputs taken so far
    int lastCount = 0;   // series closed so far
    int cycleCount = 0;
    bit inTaken = 1'b0;  // input transfer at the last rising edge

    `include "permuteModel.svh"

    permuteTop dut0 (
        .clk      (clk),
        .rst      (rst),
        .inBot    (inBot),
        .inValid  (inValid),
        .inReady  (inReady),
        .outBot   (outBot),
        .outValid (outValid),
        .outReady (outReady),
        .outLast  (outLast)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic mbfWord newBot();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // ready about 70% of the time
    function automatic bit drawReady();
        return ({$random(seed)} % 10) >= 3;
    endfunction

    function automatic int errorTotal();
        return botErrors + lastErrors + flowErrors;
    endfunction

    task automatic checkBot(input string name, input mbfWord exp, input mbfWord act);
        if (act !== exp) begin
            $display("MISMATCH %s output %0d: expected 0x%h, actual 0x%h",
                     name, outCount, exp, act);
            botErrors++;
        end
    endtask

    task automatic checkLast(input string name, input bit exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s output %0d: expected 0x%h, actual 0x%h",
                     name, outCount, exp, act);
            lastErrors++;
        end
    endtask

    // both transfers are sampled at the rising edge, inputs move only on the falling one
    always @(posedge clk) begin
        inTaken = 1'b0;
        if (!rst) begin
            if (inValid && inReady) begin
                inTaken = 1'b1;
                queueSeries(inBot);
            end
            if (outValid && outReady) begin
                if (expBot.size() == 0) begin
                    $display("output %0d arrived with nothing left to expect", outCount);
                    flowErrors++;
                end else begin
                    checkBot("outBot", expBot.pop_front(), outBot);
                    checkLast("outLast", expLast.pop_front(), outLast);
                end
                if (outLast === 1'b1) lastCount++;
                outCount++;
            end
        end
    end

    initial begin
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: outputs still missing");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int accepted;
        int sent;
        int errsBefore;
        bit full;
        rst      = 1'b1;
        inBot    = '0;
        inValid  = 1'b0;
        outReady = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst      = 1'b0;
        outReady = 1'b1;

        // nothing sent yet, so nothing may come out
        errsBefore = errorTotal();
        repeat (10) begin
            @(negedge clk);
            if (outValid !== 1'b0) begin
                $display("outValid is high although no function was sent");
                flowErrors++;
            end
            if (inReady !== 1'b1) begin
                $display("inReady is low with an empty input FIFO");
                flowErrors++;
            end
        end
        $display("reset and idle: %0d errors", errorTotal() - errsBefore);

        // burst with the output stalled, generator holds one and the FIFO the rest
        errsBefore = errorTotal();
        outReady   = 1'b0;
        accepted   = 0;
        full       = 1'b0;
        inBot      = newBot();
        inValid    = 1'b1;
        for (int i = 0; i < 12 && !full; i++) begin
            @(negedge clk);
            if (inTaken) begin
                accepted++;
                inBot = newBot();
            end else begin
                full = 1'b1;
            end
        end
        inValid = 1'b0;
        if (!full) begin
            $display("inReady never went low during the input burst");
            flowErrors++;
        end
        if (accepted != 1 + (1 << fifoDepthLog2)) begin
            $display("burst accepted %0d functions before inReady dropped, wanted %0d",
                     accepted, 1 + (1 << fifoDepthLog2));
            flowErrors++;
        end
        $display("input flow control: %0d accepted, %0d errors",
                 accepted, errorTotal() - errsBefore);

        // remaining functions with random gaps and random output stalls
        errsBefore = errorTotal();
        sent       = accepted;
        while (sent < numBots) begin
            @(negedge clk);
            outReady = drawReady();
            if (inValid && inTaken) begin
                inValid = 1'b0;
                sent++;
            end
            if (!inValid && sent < numBots && ({$random(seed)} % 3) != 0) begin
                inBot   = newBot();
                inValid = 1'b1;
            end
        end
        while (expBot.size() != 0) begin
            @(negedge clk);
            outReady = drawReady();
        end
        if (lastCount != numBots) begin
            $display("saw %0d series ends for %0d functions", lastCount, numBots);
            flowErrors++;
        end
        $display("random stream with back-pressure: %0d outputs, %0d errors",
                 outCount, errorTotal() - errsBefore);

        // everything drained, output must stay quiet
        errsBefore = errorTotal();
        outReady   = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (outValid !== 1'b0) begin
                $display("outValid is high after the last series drained");
                flowErrors++;
            end
        end
        if (expBot.size() != 0) begin
            $display("%0d expected outputs never arrived", expBot.size());
            flowErrors++;
        end
        $display("drain and idle: %0d errors", errorTotal() - errsBefore);

        $display("errors: outBot %0d, outLast %0d, other %0d",
                 botErrors, lastErrors, flowErrors);
        if (errorTotal() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
